/* common/modadd_pkg.sv */
package modadd_pkg;

  // operand geometry.
  localparam int FIELD_BITS = 381;                     // width of a, b and the result.
  localparam int NUM_LIMBS  = 3;                       // limbs, one pipeline stage each.
  localparam int LIMB_BITS  = FIELD_BITS / NUM_LIMBS;  // 127 bits per limb.

  // the running words carry one spare bit above the field.
  localparam int ACC_BITS   = FIELD_BITS + 1;          // sum or diff word plus top carry.

  // sideband tag that rides with each pair.
  localparam int CTL_BITS   = 8;                       // user tag width.

  // bls12-381 base field prime.
  // written as three 128-bit chunks, top chunk trimmed to fit 381 bits.
  // the chunk edges do not line up with the limb edges.
  localparam logic [FIELD_BITS-1:0] FIELD_P = {
    125'h1a01_11ea_397f_e69a_4b1b_a7b6_434b_acd7,      // bits 380..256.
    128'h6477_4b84_f385_12bf_6730_d2a0_f6b0_f624,      // bits 255..128.
    128'h1eab_fffe_b153_ffff_b9fe_ffff_ffff_aaab       // bits 127..0.
  };

endpackage

/* limb_stage/limb_stage.sv */
module limb_stage #(
  parameter int LIMB = 0                             // limb index, 0 is least significant.
) (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_val,
  input  logic [modadd_pkg::FIELD_BITS-1:0] i_a,
  input  logic [modadd_pkg::FIELD_BITS-1:0] i_b,
  input  logic [modadd_pkg::ACC_BITS-1:0]   i_sum,
  input  logic [modadd_pkg::ACC_BITS-1:0]   i_diff,
  input  logic                              i_borrow,
  input  logic [modadd_pkg::CTL_BITS-1:0]   i_ctl,
  input  logic                              i_sop,
  input  logic                              i_eop,
  input  logic                              i_rdy,
  output logic                              o_rdy,
  output logic                              o_val,
  output logic [modadd_pkg::FIELD_BITS-1:0] o_a,
  output logic [modadd_pkg::FIELD_BITS-1:0] o_b,
  output logic [modadd_pkg::ACC_BITS-1:0]   o_sum,
  output logic [modadd_pkg::ACC_BITS-1:0]   o_diff,
  output logic                              o_borrow,
  output logic [modadd_pkg::CTL_BITS-1:0]   o_ctl,
  output logic                              o_sop,
  output logic                              o_eop
);

  import modadd_pkg::*;

  localparam int W    = LIMB_BITS + 1;               // limb plus carry out.
  localparam int BASE = LIMB * LIMB_BITS;            // lowest bit of this limb.
  localparam logic [LIMB_BITS-1:0] P_LIMB = FIELD_P[BASE +: LIMB_BITS];

  logic [LIMB_BITS-1:0] a_limb;      // this limb of a.
  logic [LIMB_BITS-1:0] b_limb;      // this limb of b.
  logic [W-1:0]         sum_res;     // limb of a + b, top bit is carry.
  logic [W-1:0]         diff_add;    // a + b on the diff carry chain.
  logic [W:0]           diff_raw;    // signed limb of a + b - p.
  logic [W-1:0]         diff_res;    // wrapped limb written to diff word.
  logic                 borrow_nxt;  // borrow into the next limb.
  logic [ACC_BITS-1:0]  sum_nxt;     // sum word with this limb filled.
  logic [ACC_BITS-1:0]  diff_nxt;    // diff word with this limb filled.
  logic                 load;        // input pair taken this cycle.

  assign o_rdy = ~o_val | i_rdy;     // empty or being emptied.
  assign load  = i_val & o_rdy;

  always_comb begin
    a_limb = i_a[BASE +: LIMB_BITS];
    b_limb = i_b[BASE +: LIMB_BITS];

    // previous stage left its carry at the base bit of this limb.
    sum_res  = W'(a_limb) + W'(b_limb) + W'(i_sum[BASE]);
    diff_add = W'(a_limb) + W'(b_limb) + W'(i_diff[BASE]);

    // subtract the prime limb and incoming borrow, sign bit flags underflow.
    diff_raw   = (W+1)'(diff_add) - (W+1)'(P_LIMB) - (W+1)'(i_borrow);
    borrow_nxt = diff_raw[W];
    diff_res   = diff_raw[W-1:0];
    if (borrow_nxt) begin
      diff_res = diff_res + (W'(1) << LIMB_BITS);  // wrap by 2^limb_bits.
    end

    // upper limbs still zero, lower limbs already done.
    sum_nxt             = i_sum;
    sum_nxt[BASE +: W]  = sum_res;   // overwrites the carry bit it consumed.
    diff_nxt            = i_diff;
    diff_nxt[BASE +: W] = diff_res;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (o_rdy) begin
      o_val <= i_val;                // bubble in when nothing arrives.
    end
  end

  // payload only moves on an accepted pair, so it holds while stalled.
  always_ff @(posedge i_clk) begin
    if (load) begin
      o_a      <= i_a;
      o_b      <= i_b;
      o_sum    <= sum_nxt;
      o_diff   <= diff_nxt;
      o_borrow <= borrow_nxt;
      o_ctl    <= i_ctl;
      o_sop    <= i_sop;
      o_eop    <= i_eop;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the modular adder testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_modadd -f sources.f -o tb_modadd_sim

# keep the output even when the simulation stops on an assertion.
out=$(./obj_dir/tb_modadd_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi

/* sources.f */
common/modadd_pkg.sv
src/operand_loader.sv
limb_stage/limb_stage.sv
src/result_select.sv
src/modadd_top.sv
tb/tb_clock.sv
tb/modadd_properties.sv
tb/tb_modadd.sv

/* src/modadd_top.sv */
module modadd_top (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_val,
  output logic                              o_rdy,
  input  logic [modadd_pkg::FIELD_BITS-1:0] i_a,
  input  logic [modadd_pkg::FIELD_BITS-1:0] i_b,
  input  logic [modadd_pkg::CTL_BITS-1:0]   i_ctl,
  input  logic                              i_sop,
  input  logic                              i_eop,
  output logic                              o_val,
  input  logic                              i_rdy,
  output logic [modadd_pkg::FIELD_BITS-1:0] o_sum,
  output logic [modadd_pkg::CTL_BITS-1:0]   o_ctl,
  output logic                              o_sop,
  output logic                              o_eop
);

  import modadd_pkg::*;

  // index k feeds limb stage k, index NUM_LIMBS feeds the selector.
  logic                  val_w    [NUM_LIMBS+1];
  logic [FIELD_BITS-1:0] a_w      [NUM_LIMBS+1];
  logic [FIELD_BITS-1:0] b_w      [NUM_LIMBS+1];
  logic [ACC_BITS-1:0]   sum_w    [NUM_LIMBS+1];
  logic [ACC_BITS-1:0]   diff_w   [NUM_LIMBS+1];
  logic                  borrow_w [NUM_LIMBS+1];
  logic [CTL_BITS-1:0]   ctl_w    [NUM_LIMBS+1];
  logic                  sop_w    [NUM_LIMBS+1];
  logic                  eop_w    [NUM_LIMBS+1];
  logic                  sel_rdy;                 // selector can accept.

  // stage 0 starts from empty words and no borrow.
  assign sum_w[0]    = '0;
  assign diff_w[0]   = '0;
  assign borrow_w[0] = 1'b0;

  operand_loader u_loader (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_val (i_val),
    .i_a   (i_a),
    .i_b   (i_b),
    .i_ctl (i_ctl),
    .i_sop (i_sop),
    .i_eop (i_eop),
    .i_rdy (g_limb[0].rdy_up),
    .o_rdy (o_rdy),
    .o_val (val_w[0]),
    .o_a   (a_w[0]),
    .o_b   (b_w[0]),
    .o_ctl (ctl_w[0]),
    .o_sop (sop_w[0]),
    .o_eop (eop_w[0])
  );

  // ready ripples back through separate per-stage nets.
  for (genvar k = 0; k < NUM_LIMBS; k++) begin : g_limb
    logic rdy_up;  // this stage can accept.
    logic rdy_dn;  // next block can accept.

    if (k == NUM_LIMBS - 1) begin : g_last
      assign rdy_dn = sel_rdy;
    end else begin : g_mid
      assign rdy_dn = g_limb[k+1].rdy_up;
    end

    limb_stage #(
      .LIMB (k)
    ) u_stage (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_val    (val_w[k]),
      .i_a      (a_w[k]),
      .i_b      (b_w[k]),
      .i_sum    (sum_w[k]),
      .i_diff   (diff_w[k]),
      .i_borrow (borrow_w[k]),
      .i_ctl    (ctl_w[k]),
      .i_sop    (sop_w[k]),
      .i_eop    (eop_w[k]),
      .i_rdy    (rdy_dn),
      .o_rdy    (rdy_up),
      .o_val    (val_w[k+1]),
      .o_a      (a_w[k+1]),
      .o_b      (b_w[k+1]),
      .o_sum    (sum_w[k+1]),
      .o_diff   (diff_w[k+1]),
      .o_borrow (borrow_w[k+1]),
      .o_ctl    (ctl_w[k+1]),
      .o_sop    (sop_w[k+1]),
      .o_eop    (eop_w[k+1])
    );
  end

  result_select u_select (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_val    (val_w[NUM_LIMBS]),
    .i_sum    (sum_w[NUM_LIMBS]),
    .i_diff   (diff_w[NUM_LIMBS]),
    .i_borrow (borrow_w[NUM_LIMBS]),
    .i_ctl    (ctl_w[NUM_LIMBS]),
    .i_sop    (sop_w[NUM_LIMBS]),
    .i_eop    (eop_w[NUM_LIMBS]),
    .i_rdy    (i_rdy),
    .o_rdy    (sel_rdy),
    .o_val    (o_val),
    .o_sum    (o_sum),
    .o_ctl    (o_ctl),
    .o_sop    (o_sop),
    .o_eop    (o_eop)
  );

endmodule

/* src/operand_loader.sv */
module operand_loader (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_val,
  input  logic [modadd_pkg::FIELD_BITS-1:0] i_a,
  input  logic [modadd_pkg::FIELD_BITS-1:0] i_b,
  input  logic [modadd_pkg::CTL_BITS-1:0]   i_ctl,
  input  logic                              i_sop,
  input  logic                              i_eop,
  input  logic                              i_rdy,
  output logic                              o_rdy,
  output logic                              o_val,
  output logic [modadd_pkg::FIELD_BITS-1:0] o_a,
  output logic [modadd_pkg::FIELD_BITS-1:0] o_b,
  output logic [modadd_pkg::CTL_BITS-1:0]   o_ctl,
  output logic                              o_sop,
  output logic                              o_eop
);

  import modadd_pkg::*;

  // overflow entry, catches the pair that lands as downstream stalls.
  logic [FIELD_BITS-1:0] skid_a;     // overflow operand a.
  logic [FIELD_BITS-1:0] skid_b;     // overflow operand b.
  logic [CTL_BITS-1:0]   skid_ctl;   // overflow tag.
  logic                  skid_sop;   // overflow start flag.
  logic                  skid_eop;   // overflow end flag.
  logic                  skid_val;   // overflow entry occupied.
  logic                  skid_nxt;   // occupancy after this edge.
  logic                  rdy_q;      // registered upstream ready.
  logic                  in_xfer;    // pair accepted this cycle.
  logic                  main_free;  // main register may load.

  assign o_rdy     = rdy_q;                // straight from a flop.
  assign in_xfer   = i_val & rdy_q;        // upstream handshake.
  assign main_free = ~o_val | i_rdy;       // empty or leaving now.

  // overflow fills only when main is stuck and a pair still arrives.
  // rdy_q is low whenever it is full, so no third pair can come in.
  always_comb begin
    if (main_free) begin
      skid_nxt = 1'b0;                     // drains into main.
    end else begin
      skid_nxt = skid_val | in_xfer;       // hold or catch.
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val    <= 1'b0;
      skid_val <= 1'b0;
      rdy_q    <= 1'b0;                    // rises one edge after reset.
    end else begin
      skid_val <= skid_nxt;
      rdy_q    <= ~skid_nxt;               // ready while overflow is empty.
      if (main_free) begin
        o_val <= skid_val | in_xfer;       // overflow first, keeps order.
      end
    end
  end

  // main register, overflow entry has priority over the input.
  always_ff @(posedge i_clk) begin
    if (main_free) begin
      if (skid_val) begin
        o_a   <= skid_a;
        o_b   <= skid_b;
        o_ctl <= skid_ctl;
        o_sop <= skid_sop;
        o_eop <= skid_eop;
      end else if (in_xfer) begin
        o_a   <= i_a;
        o_b   <= i_b;
        o_ctl <= i_ctl;
        o_sop <= i_sop;
        o_eop <= i_eop;
      end
    end
  end

  // overflow register, loads only while main is stalled.
  always_ff @(posedge i_clk) begin
    if (~main_free & in_xfer) begin
      skid_a   <= i_a;
      skid_b   <= i_b;
      skid_ctl <= i_ctl;
      skid_sop <= i_sop;
      skid_eop <= i_eop;
    end
  end

endmodule

/* src/result_select.sv */
module result_select (
  input  logic                              i_clk,
  input  logic                              i_rst,
  input  logic                              i_val,
  input  logic [modadd_pkg::ACC_BITS-1:0]   i_sum,
  input  logic [modadd_pkg::ACC_BITS-1:0]   i_diff,
  input  logic                              i_borrow,
  input  logic [modadd_pkg::CTL_BITS-1:0]   i_ctl,
  input  logic                              i_sop,
  input  logic                              i_eop,
  input  logic                              i_rdy,
  output logic                              o_rdy,
  output logic                              o_val,
  output logic [modadd_pkg::FIELD_BITS-1:0] o_sum,
  output logic [modadd_pkg::CTL_BITS-1:0]   o_ctl,
  output logic                              o_sop,
  output logic                              o_eop
);

  import modadd_pkg::*;

  logic [FIELD_BITS-1:0] pick;  // reduced result for the pair at the input.
  logic                  load;  // input pair taken this cycle.

  assign o_rdy = ~o_val | i_rdy;  // same rule as the limb stages.
  assign load  = i_val & o_rdy;

  // final borrow set means a + b < p, keep the plain sum.
  // otherwise a + b - p is already below p.
  always_comb begin
    if (i_borrow) begin
      pick = i_sum[FIELD_BITS-1:0];
    end else begin
      pick = i_diff[FIELD_BITS-1:0];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (o_rdy) begin
      o_val <= i_val;
    end
  end

  // output register, held steady while downstream is not ready.
  always_ff @(posedge i_clk) begin
    if (load) begin
      o_sum <= pick;
      o_ctl <= i_ctl;
      o_sop <= i_sop;
      o_eop <= i_eop;
    end
  end

endmodule

/* tb/modadd_properties.sv */
module modadd_properties (
  input logic                              i_clk,
  input logic                              i_rst,
  input logic                              i_val,
  input logic                              o_rdy,
  input logic                              i_rdy,
  input logic                              o_val,
  input logic [modadd_pkg::FIELD_BITS-1:0] o_sum,
  input logic [modadd_pkg::CTL_BITS-1:0]   o_ctl,
  input logic                              o_sop,
  input logic                              o_eop
);

  import modadd_pkg::*;

  logic [NUM_LIMBS+1:0] xfer_hist;  // input transfers, newest in bit 0.
  logic [NUM_LIMBS+1:0] rdy_hist;   // i_rdy over the same cycles.

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      xfer_hist <= '0;
      rdy_hist  <= '0;
    end else begin
      xfer_hist <= {xfer_hist[NUM_LIMBS:0], i_val & o_rdy};
      rdy_hist  <= {rdy_hist[NUM_LIMBS:0], i_rdy};
    end
  end

  // one edge of reset is enough to clear the output.
  a_rst_clears: assert property (@(posedge i_clk) i_rst |=> !o_val)
    else $error("o_val still high after a reset cycle");

  a_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
    o_val |-> (o_sum < FIELD_P))
    else $error("o_sum is not below the field prime");

  a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_val && !i_rdy) |=> (o_val && $stable(o_sum) && $stable(o_ctl) &&
                           $stable(o_sop) && $stable(o_eop)))
    else $error("output changed while stalled");

  // loader, three limbs and selector, one edge each.
  a_latency: assert property (@(posedge i_clk) disable iff (i_rst)
    (xfer_hist[NUM_LIMBS+1] && (&rdy_hist)) |-> o_val)
    else $error("result missing five cycles after its input transfer");

endmodule

bind modadd_top modadd_properties u_props (
  .i_clk (i_clk),
  .i_rst (i_rst),
  .i_val (i_val),
  .o_rdy (o_rdy),
  .i_rdy (i_rdy),
  .o_val (o_val),
  .o_sum (o_sum),
  .o_ctl (o_ctl),
  .o_sop (o_sop),
  .o_eop (o_eop)
);

/* tb/tb_clock.sv */
module tb_clock (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  always #2 o_clk = ~o_clk;  // period of 4.

endmodule

/* tb/tb_modadd.sv */
module tb_modadd;

  import modadd_pkg::*;

  localparam int WAIT_LIMIT = 500;    // cycles before any wait gives up.

  logic                  clk;
  logic                  rst;
  logic                  in_val;
  logic                  up_rdy;      // dut o_rdy.
  logic                  down_rdy = 1'b1;  // dut i_rdy.
  logic [FIELD_BITS-1:0] in_a;
  logic [FIELD_BITS-1:0] in_b;
  logic [CTL_BITS-1:0]   in_ctl;
  logic                  in_sop;
  logic                  in_eop;
  logic                  out_val;
  logic [FIELD_BITS-1:0] out_sum;
  logic [CTL_BITS-1:0]   out_ctl;
  logic                  out_sop;
  logic                  out_eop;

  logic [FIELD_BITS-1:0] exp_sum_q [$];  // expected results, oldest first.
  logic [CTL_BITS-1:0]   exp_ctl_q [$];
  logic [1:0]            exp_flag_q [$]; // {sop, eop}.
  logic [FIELD_BITS-1:0] exp_sum;
  logic [CTL_BITS-1:0]   exp_ctl;
  logic [1:0]            exp_flag;
  logic [FIELD_BITS-1:0] p_m1;           // largest legal operand.
  logic [FIELD_BITS-1:0] ones_lo;        // low two limbs all ones.
  logic [31:0]           rnd;

  int    seed = 60134;
  int    errors = 0;
  int    timeouts = 0;
  int    checks = 0;
  int    stalls = 0;                     // cycles a pair waited for o_rdy.
  bit    bp_on = 1'b0;                   // random back-pressure.
  string test_name = "reset";

  tb_clock u_clock (.o_clk(clk));

  modadd_top dut0 (
    .i_clk (clk),
    .i_rst (rst),
    .i_val (in_val),
    .o_rdy (up_rdy),
    .i_a   (in_a),
    .i_b   (in_b),
    .i_ctl (in_ctl),
    .i_sop (in_sop),
    .i_eop (in_eop),
    .o_val (out_val),
    .i_rdy (down_rdy),
    .o_sum (out_sum),
    .o_ctl (out_ctl),
    .o_sop (out_sop),
    .o_eop (out_eop)
  );

  // (a + b) mod p for operands already below p.
  function automatic logic [FIELD_BITS-1:0] mod_sum(input logic [FIELD_BITS-1:0] a,
                                                    input logic [FIELD_BITS-1:0] b);
    logic [ACC_BITS-1:0] s;
    s = ACC_BITS'(a) + ACC_BITS'(b);
    if (s >= ACC_BITS'(FIELD_P)) begin
      s = s - ACC_BITS'(FIELD_P);
    end
    return s[FIELD_BITS-1:0];
  endfunction

  function automatic logic [FIELD_BITS-1:0] rand_field();
    logic [FIELD_BITS-1:0] v;
    logic [31:0]           r;
    v = '0;
    for (int i = 0; i < 12; i++) begin
      r = $random(seed);
      v = {v[FIELD_BITS-33:0], r};
    end
    if (v >= FIELD_P) begin
      v = v - FIELD_P;                   // 2^381 < 2p, one step does.
    end
    return v;
  endfunction

  function automatic logic [FIELD_BITS-1:0] rand_small();
    logic [31:0] r;
    r = $random(seed);
    return FIELD_BITS'(r[15:0]);
  endfunction

  task automatic finish_run();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  // holds the pair until the loader takes it.
  task automatic send_pair(input logic [FIELD_BITS-1:0] a, input logic [FIELD_BITS-1:0] b,
                           input logic [CTL_BITS-1:0] ctl, input logic sop, input logic eop);
    int waited;
    bit taken;
    waited = 0;
    taken  = 1'b0;
    in_val = 1'b1;
    in_a   = a;
    in_b   = b;
    in_ctl = ctl;
    in_sop = sop;
    in_eop = eop;
    while (!taken && waited < WAIT_LIMIT) begin
      taken = up_rdy;                    // registered, steady until the edge.
      if (!taken) begin
        waited++;
      end
      @(posedge clk);
      #1;
    end
    in_val = 1'b0;
    stalls += waited;
    if (!taken) begin
      $display("timeout: loader never accepted a pair in test %s", test_name);
      timeouts++;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_sum_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_sum_q.size() != 0) begin
      $display("timeout: %0d results never came out in test %s", exp_sum_q.size(), test_name);
      timeouts++;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  always @(posedge clk) begin
    #1;
    rnd      = $random(seed);
    down_rdy = bp_on ? rnd[0] : 1'b1;    // half the cycles stalled.
  end

  // scoreboard, sampled at the edge before any input moves.
  always @(posedge clk) begin
    if (rst) begin
      exp_sum_q.delete();
      exp_ctl_q.delete();
      exp_flag_q.delete();
    end else begin
      if (out_val && down_rdy) begin
        if (exp_sum_q.size() == 0) begin
          $display("unexpected result with no pair outstanding in test %s", test_name);
          errors++;
        end else begin
          exp_sum  = exp_sum_q.pop_front();
          exp_ctl  = exp_ctl_q.pop_front();
          exp_flag = exp_flag_q.pop_front();
          checks++;
          assert (out_sum == exp_sum) else begin
            $display("Fail %s: o_sum expected %h actual %h", test_name, exp_sum, out_sum);
            errors++;
          end
          assert (out_ctl == exp_ctl) else begin
            $display("Fail %s: o_ctl expected %h actual %h", test_name, exp_ctl, out_ctl);
            errors++;
          end
          assert ({out_sop, out_eop} == exp_flag) else begin
            $display("Fail %s: sop/eop expected %b actual %b", test_name, exp_flag,
                     {out_sop, out_eop});
            errors++;
          end
        end
      end
      if (in_val && up_rdy) begin
        exp_sum_q.push_back(mod_sum(in_a, in_b));
        exp_ctl_q.push_back(in_ctl);
        exp_flag_q.push_back({in_sop, in_eop});
      end
    end
  end

  initial begin
    rst     = 1'b1;
    in_val  = 1'b0;
    in_a    = '0;
    in_b    = '0;
    in_ctl  = '0;
    in_sop  = 1'b0;
    in_eop  = 1'b0;
    p_m1    = FIELD_P - FIELD_BITS'(1);
    ones_lo = {FIELD_P[FIELD_BITS-1:2*LIMB_BITS] - LIMB_BITS'(1), {(2*LIMB_BITS){1'b1}}};
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    test_name = "below_p";
    send_pair('0, '0, 8'h01, 1'b0, 1'b0);
    for (int i = 0; i < 6; i++) begin
      send_pair(rand_small(), rand_small(), CTL_BITS'(i), 1'b0, 1'b0);
    end
    send_pair(FIELD_P - FIELD_BITS'(32'h20000), rand_small(), 8'h10, 1'b0, 1'b0);
    wait_drain();

    test_name = "reduce";
    send_pair(p_m1, p_m1, 8'h20, 1'b0, 1'b0);
    send_pair(p_m1, FIELD_BITS'(1), 8'h21, 1'b0, 1'b0);  // wraps to zero.
    send_pair(p_m1, '0, 8'h22, 1'b0, 1'b0);
    send_pair(ones_lo, ones_lo, 8'h23, 1'b0, 1'b0);      // borrows cross both edges.
    send_pair(ones_lo, FIELD_BITS'(1), 8'h24, 1'b0, 1'b0);  // carry crosses both edges.
    wait_drain();

    test_name = "packet";
    for (int i = 0; i < 6; i++) begin
      rnd = $random(seed);
      send_pair(rand_field(), rand_field(), rnd[CTL_BITS-1:0], i == 0, i == 5);
    end
    wait_drain();

    test_name = "backpressure";
    bp_on = 1'b1;
    idle_cycles(1);
    for (int i = 0; i < 40; i++) begin
      send_pair(rand_field(), rand_field(), CTL_BITS'(i), i == 0, i == 39);
    end
    wait_drain();
    bp_on = 1'b0;
    idle_cycles(2);

    test_name = "throughput";
    stalls = 0;
    for (int i = 0; i < 20; i++) begin
      send_pair(rand_field(), rand_field(), CTL_BITS'(i), 1'b0, 1'b0);
    end
    assert (stalls == 0) else begin
      $display("Fail %s: stall cycles expected 0 actual %0d", test_name, stalls);
      errors++;
    end
    wait_drain();

    // long enough that results are already coming out when reset hits.
    test_name = "mid_reset";
    for (int i = 0; i < 8; i++) begin
      send_pair(rand_field(), rand_field(), CTL_BITS'(i), 1'b0, 1'b0);
    end
    rst = 1'b1;                          // pairs still in flight are dropped.
    idle_cycles(4);
    rst = 1'b0;
    test_name = "after_reset";
    for (int i = 0; i < 5; i++) begin
      send_pair(rand_field(), rand_small(), CTL_BITS'(i), 1'b0, 1'b0);
    end
    wait_drain();

    finish_run();
  end

endmodule
